/* common/lsu_pkg.sv */
// Load/store unit shared definitions
// Widths, opcode fields, exception codes and the instruction word views
`default_nettype none

package lsu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int XLEN   = 32;
    localparam int STRB_W = 4;
    localparam int EXC_W  = 6;

    // ------------------------------
    // Exception codes
    // ------------------------------
    localparam logic [EXC_W-1:0] EXC_NONE             = 6'h00;
    localparam logic [EXC_W-1:0] EXC_MISALIGNED_LOAD  = 6'h14;
    localparam logic [EXC_W-1:0] EXC_FAULT_LOAD       = 6'h15;
    localparam logic [EXC_W-1:0] EXC_MISALIGNED_STORE = 6'h16;
    localparam logic [EXC_W-1:0] EXC_FAULT_STORE      = 6'h17;

    // Major opcodes
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // Size and sign encodings in funct3
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // ------------------------------
    // Instruction word
    // ------------------------------
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_itype_t;

    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } rv_stype_t;

    // Loads read the I view, stores the S view
    typedef union packed {
        rv_itype_t itype;
        rv_stype_t stype;
    } rv_inst_u;

endpackage

`default_nettype wire

/* common/lsu_req_if.sv */
// Decoded access from address generation to the issue stage
`default_nettype none

interface lsu_req_if import lsu_pkg::*; ();

    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   data;
    logic              rd;
    logic [STRB_W-1:0] wr;
    logic              misaligned;
    // Tag flags for the response
    logic              is_load;
    logic              is_byte;
    logic              is_half;
    logic              is_signed;

    modport source (
        output addr, data, rd, wr, misaligned, is_load, is_byte, is_half, is_signed
    );

    modport sink (
        input addr, data, rd, wr, misaligned, is_load, is_byte, is_half, is_signed
    );

endinterface

`default_nettype wire

/* common/lsu_tag_if.sv */
// Per-access tags between issue, tag queue and writeback
`default_nettype none

interface lsu_tag_if import lsu_pkg::*; ();

    // Write side
    logic            push;
    logic [XLEN-1:0] push_addr;
    logic            push_load;
    logic            push_byte;
    logic            push_half;
    logic            push_signed;

    // Read side
    logic            pop;
    logic [XLEN-1:0] head_addr;
    logic            head_load;
    logic            head_byte;
    logic            head_half;
    logic            head_signed;

    modport issue (output push, push_addr, push_load, push_byte, push_half, push_signed);

    modport queue (
        input  push, push_addr, push_load, push_byte, push_half, push_signed, pop,
        output head_addr, head_load, head_byte, head_half, head_signed
    );

    modport writeback (output pop, input head_addr, head_load, head_byte, head_half, head_signed);

endinterface

`default_nettype wire

/* verilog/lsu_agen.sv */
// Load/store address generation
// Decode, effective address, alignment check and store lane steering
`default_nettype none

module lsu_agen import lsu_pkg::*;
(
    input  logic            opcode_valid_i,
    input  rv_inst_u        opcode_i,
    input  logic [XLEN-1:0] ra_operand_i,
    input  logic [XLEN-1:0] rb_operand_i,
    lsu_req_if.source       req
);

    logic [2:0]        funct3;
    logic              is_load;
    logic              is_store;
    logic              size_b;
    logic              size_h;
    logic              size_w;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   addr;
    logic              misaligned;
    logic [XLEN-1:0]   st_data;
    logic [STRB_W-1:0] st_wr;

    // ------------------------------
    // Decode
    // ------------------------------
    assign funct3 = opcode_i.itype.funct3;

    assign is_load  = opcode_valid_i && (opcode_i.itype.opcode == OPC_LOAD) &&
                      (funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
    assign is_store = opcode_valid_i && (opcode_i.stype.opcode == OPC_STORE) &&
                      (funct3 inside {F3_B, F3_H, F3_W});

    assign size_b = (funct3 == F3_B) || (funct3 == F3_BU);
    assign size_h = (funct3 == F3_H) || (funct3 == F3_HU);
    assign size_w = (funct3 == F3_W);

    // Immediate split differs between the two formats
    assign imm = is_load ? {{20{opcode_i.itype.imm[11]}}, opcode_i.itype.imm}
                         : {{20{opcode_i.stype.imm_hi[6]}}, opcode_i.stype.imm_hi,
                            opcode_i.stype.imm_lo};

    assign addr = ra_operand_i + imm;

    // Natural alignment only
    assign misaligned = (is_load || is_store) &&
                        ((size_w && (addr[1:0] != 2'b00)) || (size_h && addr[0]));

    // ------------------------------
    // Store lane steering
    // ------------------------------
    always_comb
    begin
        st_data = '0;
        st_wr   = '0;
        if (is_store && !misaligned)
        begin
            if (size_w)
            begin
                st_data = rb_operand_i;
                st_wr   = 4'b1111;
            end
            else if (size_h)
            begin
                st_data = {16'h0000, rb_operand_i[15:0]} << {addr[1], 4'b0000};
                st_wr   = 4'b0011 << {addr[1], 1'b0};
            end
            else
            begin
                st_data = {24'h000000, rb_operand_i[7:0]} << {addr[1:0], 3'b000};
                st_wr   = 4'b0001 << addr[1:0];
            end
        end
    end

    assign req.addr       = addr;
    assign req.data       = st_data;
    assign req.rd         = is_load && !misaligned;
    assign req.wr         = st_wr;
    assign req.misaligned = misaligned;
    assign req.is_load    = is_load;
    assign req.is_byte    = size_b;
    assign req.is_half    = size_h;
    assign req.is_signed  = (funct3 == F3_B) || (funct3 == F3_H);

endmodule

`default_nettype wire

/* verilog/lsu_issue.sv */
// Load/store issue stage
// Holds the request on the memory port and tracks the single outstanding access
`default_nettype none

module lsu_issue import lsu_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    lsu_req_if.sink           req,
    input  logic              mem_accept_i,
    input  logic              mem_ack_i,
    input  logic              mem_error_i,
    output logic [XLEN-1:0]   mem_addr_o,
    output logic [XLEN-1:0]   mem_data_wr_o,
    output logic              mem_rd_o,
    output logic [STRB_W-1:0] mem_wr_o,
    output logic              stall_o,
    output logic              misalign_resp_o,
    lsu_tag_if.issue          tag
);

    // E1 control
    logic              rd_q;
    logic [STRB_W-1:0] wr_q;
    logic              misaligned_q;
    // E1 payload
    logic [XLEN-1:0]   addr_q;
    logic [XLEN-1:0]   data_q;
    logic              load_q;
    logic              byte_q;
    logic              half_q;
    logic              signed_q;

    logic              pending_q;
    logic              misalign_e2_q;

    logic              ack_ok;
    logic              ack_err;
    logic              delay;
    logic              req_active;
    logic              issue;
    logic              misalign_leave;
    logic              squash;

    assign ack_ok  = mem_ack_i & ~mem_error_i;
    assign ack_err = mem_ack_i & mem_error_i;

    // Late response holds back the next request
    assign delay = pending_q & ~ack_ok;

    assign mem_rd_o      = rd_q & ~delay;
    assign mem_wr_o      = wr_q & ~{STRB_W{delay}};
    assign mem_addr_o    = {addr_q[XLEN-1:2], 2'b00};
    assign mem_data_wr_o = data_q;

    assign req_active     = mem_rd_o | (|mem_wr_o);
    assign issue          = req_active & mem_accept_i;
    assign misalign_leave = misaligned_q & ~delay;
    assign squash         = ack_err | misalign_e2_q;

    assign stall_o = (req_active & ~mem_accept_i) | delay | misaligned_q;

    // ------------------------------
    // E1 request register
    // ------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_q         <= 1'b0;
            wr_q         <= '0;
            misaligned_q <= 1'b0;
        end
        else if (squash)
        begin
            // Exception on its way, drop the next access
            rd_q         <= 1'b0;
            wr_q         <= '0;
            misaligned_q <= 1'b0;
        end
        else if (!stall_o)
        begin
            rd_q         <= req.rd;
            wr_q         <= req.wr;
            misaligned_q <= req.misaligned;
        end
        else if (misalign_leave)
            misaligned_q <= 1'b0;
    end

    always_ff @(posedge clk_i)
    begin
        if (!stall_o)
        begin
            addr_q   <= req.addr;
            data_q   <= req.data;
            load_q   <= req.is_load;
            byte_q   <= req.is_byte;
            half_q   <= req.is_half;
            signed_q <= req.is_signed;
        end
    end

    // ------------------------------
    // Outstanding and dummy response
    // ------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            pending_q     <= 1'b0;
            misalign_e2_q <= 1'b0;
        end
        else
        begin
            if (issue)
                pending_q <= 1'b1;
            else if (mem_ack_i)
                pending_q <= 1'b0;
            misalign_e2_q <= misalign_leave;
        end
    end

    assign misalign_resp_o = misalign_e2_q;

    assign tag.push        = issue | misalign_leave;
    assign tag.push_addr   = addr_q;
    assign tag.push_load   = load_q;
    assign tag.push_byte   = byte_q;
    assign tag.push_half   = half_q;
    assign tag.push_signed = signed_q;

    a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(rd_q && (|wr_q)))
        else $error("read and write strobes both set in E1");

    // Next issue waits for the ack of the previous one
    a_single_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
        issue |=> (!issue until mem_ack_i))
        else $error("second request issued while one is outstanding");

endmodule

`default_nettype wire

/* verilog/lsu_tag_fifo.sv */
// Tag queue for accesses awaiting their response
`default_nettype none

module lsu_tag_fifo import lsu_pkg::*;
#(
    parameter int DEPTH = 2
)
(
    input  logic     clk_i,
    input  logic     rst_i,
    lsu_tag_if.queue tag
);

    localparam int PTR_W   = $clog2(DEPTH);
    localparam int CNT_W   = $clog2(DEPTH + 1);
    localparam int ENTRY_W = XLEN + 4;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    logic [ENTRY_W-1:0] entry_q [DEPTH];
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               accept;
    logic               valid;
    logic               do_push;
    logic               do_pop;

    assign accept  = (count_q != CNT_W'(DEPTH));
    assign valid   = (count_q != '0);
    assign do_push = tag.push & accept;
    assign do_pop  = tag.pop & valid;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
            if (do_pop)
                rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
            if (do_push && !do_pop)
                count_q <= count_q + 1'b1;
            else if (!do_push && do_pop)
                count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (do_push)
            entry_q[wr_ptr_q] <= {tag.push_addr, tag.push_load, tag.push_byte,
                                  tag.push_half, tag.push_signed};
    end

    // Head visible in the same cycle
    assign {tag.head_addr, tag.head_load, tag.head_byte, tag.head_half, tag.head_signed} =
        entry_q[rd_ptr_q];

    a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i) tag.push |-> accept)
        else $error("tag pushed into a full queue");

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i) tag.pop |-> valid)
        else $error("response with no tag queued");

endmodule

`default_nettype wire

/* verilog/lsu_writeback.sv */
// Load/store writeback
// Load data extraction, sign extension and exception encoding
`default_nettype none

module lsu_writeback import lsu_pkg::*;
(
    input  logic             mem_ack_i,
    input  logic             mem_error_i,
    input  logic [XLEN-1:0]  mem_data_rd_i,
    input  logic             misalign_resp_i,
    lsu_tag_if.writeback     tag,
    output logic             writeback_valid_o,
    output logic [XLEN-1:0]  writeback_value_o,
    output logic [EXC_W-1:0] writeback_exception_o
);

    logic        fault_bus;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign tag.pop           = mem_ack_i | misalign_resp_i;
    assign writeback_valid_o = mem_ack_i | misalign_resp_i;

    assign fault_bus = mem_ack_i & mem_error_i;

    // Lane picked by the low address bits of the tag
    assign byte_sel = mem_data_rd_i[{tag.head_addr[1:0], 3'b000} +: 8];
    assign half_sel = mem_data_rd_i[{tag.head_addr[1], 4'b0000} +: 16];

    always_comb
    begin
        writeback_value_o = '0;
        // Faulting address goes out on the value bus
        if (fault_bus || misalign_resp_i)
            writeback_value_o = tag.head_addr;
        else if (mem_ack_i && tag.head_load)
        begin
            if (tag.head_byte)
                writeback_value_o = {{24{tag.head_signed & byte_sel[7]}}, byte_sel};
            else if (tag.head_half)
                writeback_value_o = {{16{tag.head_signed & half_sel[15]}}, half_sel};
            else
                writeback_value_o = mem_data_rd_i;
        end
    end

    always_comb
    begin
        if (misalign_resp_i)
            writeback_exception_o = tag.head_load ? EXC_MISALIGNED_LOAD : EXC_MISALIGNED_STORE;
        else if (fault_bus)
            writeback_exception_o = tag.head_load ? EXC_FAULT_LOAD : EXC_FAULT_STORE;
        else
            writeback_exception_o = EXC_NONE;
    end

    // One response per cycle, otherwise a queued tag would be lost
    a_resp_exclusive: assert final (!(mem_ack_i && misalign_resp_i))
        else $error("memory ack in the same cycle as a misalignment response");

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
// Load/store unit top level
// Address generation, issue, tag queue and writeback stages
`default_nettype none

module lsu_top import lsu_pkg::*;
#(
    parameter int DEPTH = 2
)
(
    input  logic              clk_i,
    input  logic              rst_i,
    // Core side
    input  logic              opcode_valid_i,
    input  logic [XLEN-1:0]   opcode_opcode_i,
    input  logic [XLEN-1:0]   opcode_ra_operand_i,
    input  logic [XLEN-1:0]   opcode_rb_operand_i,
    // Memory side
    output logic [XLEN-1:0]   mem_addr_o,
    output logic [XLEN-1:0]   mem_data_wr_o,
    output logic              mem_rd_o,
    output logic [STRB_W-1:0] mem_wr_o,
    input  logic              mem_accept_i,
    input  logic              mem_ack_i,
    input  logic              mem_error_i,
    input  logic [XLEN-1:0]   mem_data_rd_i,
    // Writeback
    output logic              writeback_valid_o,
    output logic [XLEN-1:0]   writeback_value_o,
    output logic [EXC_W-1:0]  writeback_exception_o,
    output logic              stall_o
);

    lsu_req_if req_bus ();
    lsu_tag_if tag_bus ();

    logic misalign_resp;

    lsu_agen u_agen (
        .opcode_valid_i (opcode_valid_i),
        .opcode_i       (opcode_opcode_i),
        .ra_operand_i   (opcode_ra_operand_i),
        .rb_operand_i   (opcode_rb_operand_i),
        .req            (req_bus.source)
    );

    lsu_issue u_issue (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .req             (req_bus.sink),
        .mem_accept_i    (mem_accept_i),
        .mem_ack_i       (mem_ack_i),
        .mem_error_i     (mem_error_i),
        .mem_addr_o      (mem_addr_o),
        .mem_data_wr_o   (mem_data_wr_o),
        .mem_rd_o        (mem_rd_o),
        .mem_wr_o        (mem_wr_o),
        .stall_o         (stall_o),
        .misalign_resp_o (misalign_resp),
        .tag             (tag_bus.issue)
    );

    lsu_tag_fifo #(
        .DEPTH (DEPTH)
    ) u_tag_fifo (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .tag   (tag_bus.queue)
    );

    lsu_writeback u_writeback (
        .mem_ack_i             (mem_ack_i),
        .mem_error_i           (mem_error_i),
        .mem_data_rd_i         (mem_data_rd_i),
        .misalign_resp_i       (misalign_resp),
        .tag                   (tag_bus.writeback),
        .writeback_valid_o     (writeback_valid_o),
        .writeback_value_o     (writeback_value_o),
        .writeback_exception_o (writeback_exception_o)
    );

endmodule

`default_nettype wire

/* verif/tb_lsu_top.sv */
// Load/store unit testbench
// Random loads and stores against a memory responder and a reference model
`default_nettype none

module tb_lsu_top import lsu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TOTAL_OPS  = 130;
    localparam int MAX_CYCLES = 20 * TOTAL_OPS;

    logic              clk_i;
    logic              rst_i;
    logic              opcode_valid_i;
    logic [XLEN-1:0]   opcode_opcode_i;
    logic [XLEN-1:0]   opcode_ra_operand_i;
    logic [XLEN-1:0]   opcode_rb_operand_i;
    logic [XLEN-1:0]   mem_addr_o;
    logic [XLEN-1:0]   mem_data_wr_o;
    logic              mem_rd_o;
    logic [STRB_W-1:0] mem_wr_o;
    logic              mem_accept_i;
    logic              mem_ack_i;
    logic              mem_error_i;
    logic [XLEN-1:0]   mem_data_rd_i;
    logic              writeback_valid_o;
    logic [XLEN-1:0]   writeback_value_o;
    logic [EXC_W-1:0]  writeback_exception_o;
    logic              stall_o;

    // Responder memory and its reference copy
    logic [XLEN-1:0]   mem [64];
    logic [XLEN-1:0]   ref_mem [64];

    string             cur_test;
    int                error_count;
    int                checks_done;
    int                test_base;
    int                test_ops;
    int                refused_cycles;
    int                cycle_count;

    // Expected request of the access in flight
    logic              exp_rd;
    logic [STRB_W-1:0] exp_wr;
    logic [XLEN-1:0]   exp_addr;
    logic [XLEN-1:0]   exp_data;

    lsu_top #(
        .DEPTH (2)
    ) i_dut (
        .clk_i                 (clk_i),
        .rst_i                 (rst_i),
        .opcode_valid_i        (opcode_valid_i),
        .opcode_opcode_i       (opcode_opcode_i),
        .opcode_ra_operand_i   (opcode_ra_operand_i),
        .opcode_rb_operand_i   (opcode_rb_operand_i),
        .mem_addr_o            (mem_addr_o),
        .mem_data_wr_o         (mem_data_wr_o),
        .mem_rd_o              (mem_rd_o),
        .mem_wr_o              (mem_wr_o),
        .mem_accept_i          (mem_accept_i),
        .mem_ack_i             (mem_ack_i),
        .mem_error_i           (mem_error_i),
        .mem_data_rd_i         (mem_data_rd_i),
        .writeback_valid_o     (writeback_valid_o),
        .writeback_value_o     (writeback_value_o),
        .writeback_exception_o (writeback_exception_o),
        .stall_o               (stall_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever
            #2 clk_i = ~clk_i;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES)
        begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic report_mismatch(input string what, input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        error_count++;
    endtask

    task automatic report_problem(input string msg);
        $display("[FAIL] %s: %s", cur_test, msg);
        error_count++;
    endtask

    // ------------------------------
    // Memory responder
    // ------------------------------
    initial
    begin : responder
        logic              held;
        logic [XLEN-1:0]   held_addr;
        logic [XLEN-1:0]   held_data;
        logic              held_rd;
        logic [STRB_W-1:0] held_wr;
        logic [XLEN-1:0]   lane_mask;
        logic [5:0]        ack_idx;
        logic              ack_fault;
        int                ack_cnt;
        int                k;

        mem_accept_i  = 1'b1;
        mem_ack_i     = 1'b0;
        mem_error_i   = 1'b0;
        mem_data_rd_i = '0;
        held          = 1'b0;
        ack_idx       = '0;
        ack_fault     = 1'b0;
        ack_cnt       = 0;
        forever
        begin
            @(negedge clk_i);
            if (held)
            begin
                checks_done++;
                if (mem_addr_o !== held_addr || mem_data_wr_o !== held_data ||
                    mem_rd_o !== held_rd || mem_wr_o !== held_wr)
                    report_problem("request changed while mem_accept_i was low");
            end
            held = 1'b0;
            if (mem_rd_o || (|mem_wr_o))
            begin
                for (k = 0; k < STRB_W; k++)
                    lane_mask[8*k +: 8] = {8{exp_wr[k]}};
                checks_done++;
                if (mem_rd_o !== exp_rd)
                    report_mismatch("mem_rd_o", exp_rd, mem_rd_o);
                if (mem_wr_o !== exp_wr)
                    report_mismatch("mem_wr_o", exp_wr, mem_wr_o);
                if (mem_addr_o[1:0] !== 2'b00)
                    report_mismatch("mem_addr_o low bits", 0, mem_addr_o[1:0]);
                if (mem_addr_o !== {exp_addr[XLEN-1:2], 2'b00})
                    report_mismatch("mem_addr_o", {exp_addr[XLEN-1:2], 2'b00}, mem_addr_o);
                if ((mem_data_wr_o & lane_mask) !== (exp_data & lane_mask))
                    report_mismatch("mem_data_wr_o", exp_data & lane_mask,
                                    mem_data_wr_o & lane_mask);
                if (!mem_accept_i)
                begin
                    refused_cycles++;
                    if (!stall_o)
                        report_problem("stall_o low while the request is refused");
                    held      = 1'b1;
                    held_addr = mem_addr_o;
                    held_data = mem_data_wr_o;
                    held_rd   = mem_rd_o;
                    held_wr   = mem_wr_o;
                end
                else
                begin
                    // Taken at the coming edge
                    ack_idx   = mem_addr_o[7:2];
                    ack_fault = mem_addr_o[8];
                    ack_cnt   = 1 + ($urandom % 3);
                    if (!ack_fault)
                    begin
                        for (k = 0; k < STRB_W; k++)
                            if (mem_wr_o[k])
                                mem[ack_idx][8*k +: 8] = mem_data_wr_o[8*k +: 8];
                    end
                end
            end
            @(posedge clk_i);
            #1;
            mem_accept_i = (($urandom % 3) != 0);
            mem_ack_i    = 1'b0;
            mem_error_i  = 1'b0;
            if (ack_cnt > 0)
            begin
                ack_cnt--;
                if (ack_cnt == 0)
                begin
                    mem_ack_i     = 1'b1;
                    mem_error_i   = ack_fault;
                    mem_data_rd_i = ack_fault ? $urandom : mem[ack_idx];
                end
            end
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    function automatic logic [2:0] pick_f3(input logic is_load);
        logic [2:0] f3;

        case ($urandom % (is_load ? 5 : 3))
            0: f3 = F3_B;
            1: f3 = F3_H;
            2: f3 = F3_W;
            3: f3 = F3_BU;
            default: f3 = F3_HU;
        endcase
        return f3;
    endfunction

    // Byte offset in the word, aligned or not for the access size
    function automatic logic [1:0] pick_off(input logic [2:0] f3, input logic aligned);
        logic [1:0] off;

        off = 2'($urandom);
        if (f3[1:0] == 2'b10)
            off = aligned ? 2'b00 : 2'(1 + $urandom % 3);
        else if (f3[1:0] == 2'b01)
            off[0] = ~aligned;
        return off;
    endfunction

    function automatic logic [XLEN-1:0] pick_addr(input logic fault, input logic [1:0] off);
        logic [XLEN-1:0] addr;

        addr      = $urandom;
        addr[8]   = fault;
        addr[1:0] = off;
        return addr;
    endfunction

    task automatic start_test(input string name);
        cur_test  = name;
        test_base = error_count;
        test_ops  = 0;
    endtask

    task automatic finish_test();
        $display("%s: %0d ops, %0d errors", cur_test, test_ops, error_count - test_base);
    endtask

    // One load or store through the model, then wait for its writeback
    task automatic run_access(input logic is_load, input logic [2:0] f3,
                              input logic [XLEN-1:0] addr, input logic [XLEN-1:0] rb);
        logic [11:0]      imm;
        logic [XLEN-1:0]  inst;
        logic [XLEN-1:0]  word;
        logic [XLEN-1:0]  exp_value;
        logic [EXC_W-1:0] exp_exc;
        logic             size_b;
        logic             size_h;
        logic             mis;
        logic             value_checked;
        logic             done;
        int               k;

        imm    = 12'($urandom);
        size_b = (f3[1:0] == 2'b00);
        size_h = (f3[1:0] == 2'b01);
        mis    = ((f3[1:0] == 2'b10) && (addr[1:0] != 2'b00)) || (size_h && addr[0]);
        if (is_load)
            inst = {imm, 5'd5, f3, 5'd6, OPC_LOAD};
        else
            inst = {imm[11:5], 5'd7, 5'd5, f3, imm[4:0], OPC_STORE};

        exp_addr = addr;
        exp_rd   = is_load && !mis;
        exp_wr   = '0;
        exp_data = '0;
        if (!is_load && !mis)
        begin
            if (size_b)
            begin
                case (addr[1:0])
                    2'd0: exp_wr = 4'b0001;
                    2'd1: exp_wr = 4'b0010;
                    2'd2: exp_wr = 4'b0100;
                    default: exp_wr = 4'b1000;
                endcase
                exp_data = {4{rb[7:0]}};
            end
            else if (size_h)
            begin
                exp_wr   = addr[1] ? 4'b1100 : 4'b0011;
                exp_data = {2{rb[15:0]}};
            end
            else
            begin
                exp_wr   = 4'b1111;
                exp_data = rb;
            end
        end

        // Expected writeback, misalignment before bus fault
        exp_exc       = EXC_NONE;
        exp_value     = addr;
        value_checked = 1'b1;
        word          = ref_mem[addr[7:2]] >> (8 * addr[1:0]);
        if (mis)
            exp_exc = is_load ? EXC_MISALIGNED_LOAD : EXC_MISALIGNED_STORE;
        else if (addr[8])
            exp_exc = is_load ? EXC_FAULT_LOAD : EXC_FAULT_STORE;
        else if (is_load)
        begin
            if (size_b)
                exp_value = {{24{~f3[2] & word[7]}}, word[7:0]};
            else if (size_h)
                exp_value = {{16{~f3[2] & word[15]}}, word[15:0]};
            else
                exp_value = word;
        end
        else
        begin
            value_checked = 1'b0;
            for (k = 0; k < STRB_W; k++)
                if (exp_wr[k])
                    ref_mem[addr[7:2]][8*k +: 8] = exp_data[8*k +: 8];
        end

        opcode_valid_i      = 1'b1;
        opcode_opcode_i     = inst;
        opcode_ra_operand_i = addr - {{20{imm[11]}}, imm};
        opcode_rb_operand_i = rb;
        done = 1'b0;
        while (!done)
        begin
            @(negedge clk_i);
            done = !stall_o;
            @(posedge clk_i);
            #1;
        end
        opcode_valid_i = 1'b0;
        done = 1'b0;
        while (!done)
        begin
            @(negedge clk_i);
            done = writeback_valid_o;
            if (!done)
            begin
                @(posedge clk_i);
                #1;
            end
        end
        checks_done++;
        if (writeback_exception_o !== exp_exc)
            report_mismatch("exception", exp_exc, writeback_exception_o);
        if (value_checked && (writeback_value_o !== exp_value))
            report_mismatch("value", exp_value, writeback_value_o);
        test_ops++;
        @(posedge clk_i);
        #1;
    endtask

    // Opcode outside the unit, held valid for three cycles
    task automatic run_other_op();
        logic [XLEN-1:0] inst;
        int              i;

        inst      = $urandom;
        inst[6:0] = ($urandom % 2) ? 7'b0110011 : 7'b0010011;
        exp_rd    = 1'b0;
        exp_wr    = '0;
        opcode_valid_i      = 1'b1;
        opcode_opcode_i     = inst;
        opcode_ra_operand_i = $urandom;
        opcode_rb_operand_i = $urandom;
        for (i = 0; i < 5; i++)
        begin
            if (i == 3)
                opcode_valid_i = 1'b0;
            @(negedge clk_i);
            checks_done++;
            if (writeback_valid_o)
                report_problem("writeback from a non-memory opcode");
            @(posedge clk_i);
            #1;
        end
        test_ops++;
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial
    begin : main
        logic            is_load;
        logic [2:0]      f3;
        logic [XLEN-1:0] addr;
        int              i;
        int              j;

        void'($urandom(74));
        rst_i               = 1'b1;
        opcode_valid_i      = 1'b0;
        opcode_opcode_i     = '0;
        opcode_ra_operand_i = '0;
        opcode_rb_operand_i = '0;
        error_count         = 0;
        checks_done         = 0;
        refused_cycles      = 0;
        exp_rd              = 1'b0;
        exp_wr              = '0;
        exp_addr            = '0;
        exp_data            = '0;
        cur_test            = "reset";
        for (i = 0; i < 64; i++)
        begin
            mem[i]     = (i + 1) * 32'h9e37_79b9;
            ref_mem[i] = (i + 1) * 32'h9e37_79b9;
        end
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        start_test("store_load");
        for (i = 0; i < 12; i++)
        begin
            f3   = pick_f3(1'b0);
            addr = pick_addr(1'b0, pick_off(f3, 1'b1));
            run_access(1'b0, f3, addr, $urandom);
            // funct3 3 is LD, outside RV32
            for (j = 0; j < 6; j++)
                if (j != 3)
                    run_access(1'b1, 3'(j), {addr[XLEN-1:2], pick_off(3'(j), 1'b1)}, $urandom);
        end
        finish_test();

        start_test("byte_lanes");
        for (i = 0; i < 16; i++)
        begin
            f3 = pick_f3(1'b0);
            run_access(1'b0, f3, pick_addr(1'b0, pick_off(f3, 1'b1)), $urandom);
        end
        finish_test();

        start_test("misaligned");
        for (i = 0; i < 16; i++)
        begin
            case ($urandom % 5)
                0: {is_load, f3} = {1'b1, F3_H};
                1: {is_load, f3} = {1'b1, F3_HU};
                2: {is_load, f3} = {1'b1, F3_W};
                3: {is_load, f3} = {1'b0, F3_H};
                default: {is_load, f3} = {1'b0, F3_W};
            endcase
            run_access(is_load, f3, pick_addr(1'($urandom), pick_off(f3, 1'b0)), $urandom);
        end
        finish_test();

        start_test("bus_error");
        for (i = 0; i < 12; i++)
        begin
            is_load = 1'($urandom);
            f3      = pick_f3(is_load);
            run_access(is_load, f3, pick_addr(1'b1, pick_off(f3, 1'b1)), $urandom);
        end
        finish_test();

        start_test("back_pressure");
        refused_cycles = 0;
        for (i = 0; i < 14; i++)
        begin
            if (i % 3 == 2)
                run_other_op();
            else
            begin
                is_load = 1'($urandom);
                f3      = pick_f3(is_load);
                run_access(is_load, f3, pick_addr(1'b0, pick_off(f3, 1'b1)), $urandom);
            end
        end
        if (refused_cycles == 0)
            report_problem("no refused request was seen");
        finish_test();

        $display("Done: %0d checks, %0d errors", checks_done, error_count);
        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_lsu.f */
common/lsu_pkg.sv
common/lsu_req_if.sv
common/lsu_tag_if.sv
verilog/lsu_agen.sv
verilog/lsu_issue.sv
verilog/lsu_tag_fifo.sv
verilog/lsu_writeback.sv
verilog/lsu_top.sv
verif/tb_lsu_top.sv
